//--- hdl/icache_pkg.sv
// Shared widths and line geometry for the refill model. line_lo_bit must equal tid_w + 2 and index_hi_bit must stay below adr_w
package icache_pkg;

	// ========================================================================
	// Bus widths
	// ========================================================================

	// Byte address width seen by the requesters, the arbiter and the memory
	localparam int unsigned adr_w = 16;

	// One beat carries a single 32-bit instruction word
	localparam int unsigned data_w = 32;

	// ========================================================================
	// Line geometry
	// ========================================================================

	// A line is four beats, so 16 bytes on an aligned boundary
	localparam int unsigned beats_per_line = 4;
	localparam int unsigned line_w = beats_per_line * data_w;

	// Address bits below this one are zero in a line address
	localparam int unsigned line_lo_bit = 4;

	// Bits line_lo_bit up to this one select the cache index used by the snoop
	localparam int unsigned index_hi_bit = 7;

	// The transaction id is simply the beat number inside the line
	localparam int unsigned tid_w = 2;

	// ========================================================================
	// Retry and memory sizing
	// ========================================================================

	// Minimum back-off in cycles before the LFSR is consulted
	localparam int unsigned backoff_min = 6;

	// Word depth of the line memory and the width of its word index
	localparam int unsigned mem_words = 256;
	localparam int unsigned mem_idx_w = $clog2(mem_words);

	// Identifies which requester owns a beat or caused a snoop
	typedef logic [0:0] cid_t;

endpackage

//--- hdl/lfsr17.sv
// Free-running 17-bit Fibonacci LFSR. seed must be nonzero or the register locks up at zero
`timescale 1ns/100ps

module lfsr17 #(
	parameter logic [16:0] seed = 17'h0ace1
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        ce,
	output logic [16:0] o
);

	// Taps at 17 and 14 give the full 2^17 - 1 sequence
	logic feedback;

	assign feedback = o[16] ^ o[13];

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			o <= seed;
		end else if (ce) begin
			o <= {o[15:0], feedback};
		end
	end

	// An all-zero state would stall the back-off of the owning requester forever
	a_never_zero: assert property (@(posedge clk) disable iff (rst)
		ce |=> (o != '0));

endmodule

//--- hdl/icache_line_requester.sv
// One miss at a time per requester. miss_adr must stay stable from miss_req until miss_ack falls
`timescale 1ns/100ps

module icache_line_requester #(
	parameter icache_pkg::cid_t cid = 1'b0
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          miss_req,
	input  logic [icache_pkg::adr_w-1:0]  miss_adr,
	output logic                          miss_ack,
	output logic [icache_pkg::line_w-1:0] fill_data,
	output logic                          beat_req,
	output logic [icache_pkg::adr_w-1:0]  beat_adr,
	output logic [icache_pkg::tid_w-1:0]  beat_tid,
	input  logic                          beat_ack,
	input  logic [icache_pkg::data_w-1:0] beat_rdata,
	input  logic [icache_pkg::tid_w-1:0]  beat_rtid,
	input  logic                          snoop_v,
	input  logic [icache_pkg::adr_w-1:0]  snoop_adr,
	input  icache_pkg::cid_t              snoop_cid
);

	typedef enum logic [2:0] {
		st_start,
		st_idle,
		st_issue,
		st_release,
		st_done,
		st_backoff
	} state_t;

	// Channel 1 leaves reset later than channel 0 so the two do not start in step
	localparam logic [3:0] start_last = 4'({cid, 2'b00}) + 4'd3;

	state_t                          state;
	logic [3:0]                      wait_cnt;
	logic [icache_pkg::tid_w-1:0]    beat_cnt;
	logic                            abort_pend;
	logic                            abort;
	logic                            snoop_hit;
	logic                            issue_now;
	logic                            take_now;
	logic [icache_pkg::adr_w-1:0]    madr;
	logic [icache_pkg::adr_w-1:0]    line_adr;
	logic [icache_pkg::adr_w-1:0]    next_adr;
	logic [icache_pkg::adr_w-1:0]    vtags [icache_pkg::beats_per_line];
	logic [icache_pkg::tid_w-1:0]    fill_slot;
	logic [icache_pkg::line_w-1:0]   line;
	logic [16:0]                     lfsr_o;

	// Each channel gets its own seed so their back-off delays drift apart
	lfsr17 #(
		.seed({8'h5a, 8'h3c, cid})
	) lfsr_i (
		.clk(clk),
		.rst(rst),
		.ce(state != st_start),
		.o(lfsr_o)
	);

	// Low address bits of the miss are dropped to get the aligned line
	assign line_adr = {miss_adr[icache_pkg::adr_w-1:icache_pkg::line_lo_bit],
		{icache_pkg::line_lo_bit{1'b0}}};

	// Beat n of the line sits n words above the line base
	assign next_adr = madr | (icache_pkg::adr_w'(beat_cnt) << 2);

	// Only the cache index matters, a snoop from this channel is its own traffic
	assign snoop_hit = ((state == st_issue) || (state == st_release)) && snoop_v &&
		(snoop_cid != cid) &&
		(snoop_adr[icache_pkg::index_hi_bit:icache_pkg::line_lo_bit] ==
		madr[icache_pkg::index_hi_bit:icache_pkg::line_lo_bit]);

	assign abort = abort_pend || snoop_hit;

	// A new beat goes out only when nothing is raised and no abort is waiting
	assign issue_now = (state == st_issue) && !beat_req && !abort;
	assign take_now = (state == st_issue) && beat_req && beat_ack;

	// The word offset recorded for this id decides where the word lands
	assign fill_slot = vtags[beat_rtid][icache_pkg::line_lo_bit-1:2];

	assign fill_data = line;

	// ========================================================================
	// Refill FSM
	// ========================================================================

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state <= st_start;
			wait_cnt <= '0;
			beat_cnt <= '0;
			beat_req <= 1'b0;
			miss_ack <= 1'b0;
			abort_pend <= 1'b0;
		end else begin
			// A hit is remembered until the raised beat has finished
			if (snoop_hit)
				abort_pend <= 1'b1;
			case (state)
			st_start: begin
				if (wait_cnt == start_last) begin
					wait_cnt <= '0;
					state <= st_idle;
				end else begin
					wait_cnt <= wait_cnt + 4'd1;
				end
			end
			st_idle: begin
				if (miss_req) begin
					beat_cnt <= '0;
					abort_pend <= 1'b0;
					state <= st_issue;
				end
			end
			st_issue: begin
				if (!beat_req) begin
					if (abort) begin
						wait_cnt <= '0;
						abort_pend <= 1'b0;
						state <= st_backoff;
					end else begin
						beat_req <= 1'b1;
					end
				end else if (beat_ack) begin
					beat_req <= 1'b0;
					state <= st_release;
				end
			end
			st_release: begin
				// Wait for the ack to fall, which closes the four-phase cycle
				if (!beat_ack) begin
					if (abort) begin
						wait_cnt <= '0;
						abort_pend <= 1'b0;
						state <= st_backoff;
					end else if (beat_cnt == icache_pkg::tid_w'(icache_pkg::beats_per_line - 1)) begin
						miss_ack <= 1'b1;
						state <= st_done;
					end else begin
						beat_cnt <= beat_cnt + 1'b1;
						state <= st_issue;
					end
				end
			end
			st_done: begin
				if (!miss_req) begin
					miss_ack <= 1'b0;
					state <= st_idle;
				end
			end
			st_backoff: begin
				// Fixed minimum first, then a random tail from the LFSR
				if (wait_cnt == 4'(icache_pkg::backoff_min)) begin
					if (lfsr_o[2:0] == 3'b111) begin
						beat_cnt <= '0;
						state <= st_issue;
					end
				end else begin
					wait_cnt <= wait_cnt + 4'd1;
				end
			end
			default: state <= st_start;
			endcase
		end
	end

	// Line base, beat address, id table and the assembled line
	always_ff @(posedge clk) begin
		if ((state == st_idle) && miss_req)
			madr <= line_adr;
		if (issue_now) begin
			beat_adr <= next_adr;
			beat_tid <= beat_cnt;
			vtags[beat_cnt] <= next_adr;
		end
		if (take_now)
			line[fill_slot * icache_pkg::data_w +: icache_pkg::data_w] <= beat_rdata;
	end

	// The arbiter and memory see a stable address for the whole beat
	a_adr_stable: assert property (@(posedge clk) disable iff (rst)
		beat_req |=> $stable(beat_adr));

	// The id coming back through arbiter and memory matches the raised beat
	a_rtid_match: assert property (@(posedge clk) disable iff (rst)
		$rose(beat_ack) |-> (beat_req && (beat_rtid == beat_tid)));

endmodule

//--- hdl/bus_arbiter.sv
// Two requesters share one memory port. A grant lasts one beat and ties alternate between channels
`timescale 1ns/100ps

module bus_arbiter (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          beat_req_0,
	input  logic [icache_pkg::adr_w-1:0]  beat_adr_0,
	input  logic [icache_pkg::tid_w-1:0]  beat_tid_0,
	output logic                          beat_ack_0,
	output logic [icache_pkg::data_w-1:0] beat_rdata_0,
	output logic [icache_pkg::tid_w-1:0]  beat_rtid_0,
	input  logic                          beat_req_1,
	input  logic [icache_pkg::adr_w-1:0]  beat_adr_1,
	input  logic [icache_pkg::tid_w-1:0]  beat_tid_1,
	output logic                          beat_ack_1,
	output logic [icache_pkg::data_w-1:0] beat_rdata_1,
	output logic [icache_pkg::tid_w-1:0]  beat_rtid_1,
	output logic                          mem_req,
	output logic [icache_pkg::adr_w-1:0]  mem_adr,
	output logic [icache_pkg::tid_w-1:0]  mem_tid,
	input  logic                          mem_ack,
	input  logic [icache_pkg::data_w-1:0] mem_rdata,
	input  logic [icache_pkg::tid_w-1:0]  mem_rtid,
	output logic                          snoop_v,
	output logic [icache_pkg::adr_w-1:0]  snoop_adr,
	output icache_pkg::cid_t              snoop_cid
);

	logic             owner_v;
	icache_pkg::cid_t owner;
	icache_pkg::cid_t last_owner;
	icache_pkg::cid_t pick;
	logic             any_req;
	logic             own_req;
	logic             sel_0;
	logic             sel_1;

	assign any_req = beat_req_0 || beat_req_1;

	// On a tie the channel that did not own the bus last time goes first
	always_comb begin
		if (beat_req_0 && beat_req_1)
			pick = ~last_owner;
		else if (beat_req_1)
			pick = 1'b1;
		else
			pick = 1'b0;
	end

	assign sel_0 = owner_v && (owner == 1'b0);
	assign sel_1 = owner_v && (owner == 1'b1);
	assign own_req = owner ? beat_req_1 : beat_req_0;

	// Request side passes straight through from the owner
	assign mem_req = owner_v && own_req;
	assign mem_adr = owner ? beat_adr_1 : beat_adr_0;
	assign mem_tid = owner ? beat_tid_1 : beat_tid_0;

	// Responses go to the owner only, the other channel sees zeros
	assign beat_ack_0 = sel_0 && mem_ack;
	assign beat_ack_1 = sel_1 && mem_ack;
	assign beat_rdata_0 = sel_0 ? mem_rdata : '0;
	assign beat_rdata_1 = sel_1 ? mem_rdata : '0;
	assign beat_rtid_0 = sel_0 ? mem_rtid : '0;
	assign beat_rtid_1 = sel_1 ? mem_rtid : '0;

	// ========================================================================
	// Owner register
	// ========================================================================

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			owner_v <= 1'b0;
			owner <= 1'b0;
			last_owner <= 1'b1;
			snoop_v <= 1'b0;
		end else begin
			snoop_v <= 1'b0;
			if (!owner_v) begin
				if (any_req) begin
					owner_v <= 1'b1;
					owner <= pick;
					snoop_v <= 1'b1;
				end
			end else if (!own_req && !mem_ack) begin
				// Both halves of the handshake are low so the beat is over
				owner_v <= 1'b0;
				last_owner <= owner;
			end
		end
	end

	// The snoop carries the granted address for one cycle
	always_ff @(posedge clk) begin
		if (!owner_v && any_req) begin
			snoop_adr <= pick ? beat_adr_1 : beat_adr_0;
			snoop_cid <= pick;
		end
	end

	// Neither a request nor the memory's ack may exist outside a grant
	a_owned: assert property (@(posedge clk) disable iff (rst)
		(mem_req || mem_ack) |-> owner_v);

endmodule

//--- hdl/line_memory.sv
// Word RAM answering one beat per handshake. Address bits above 2 + mem_idx_w are ignored, so addresses wrap
`timescale 1ns/100ps

module line_memory (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          mem_req,
	input  logic [icache_pkg::adr_w-1:0]  mem_adr,
	input  logic [icache_pkg::tid_w-1:0]  mem_tid,
	output logic                          mem_ack,
	output logic [icache_pkg::data_w-1:0] mem_rdata,
	output logic [icache_pkg::tid_w-1:0]  mem_rtid,
	input  logic                          pre_we,
	input  logic [icache_pkg::adr_w-1:0]  pre_adr,
	input  logic [icache_pkg::data_w-1:0] pre_wdata
);

	logic [icache_pkg::data_w-1:0]    ram [icache_pkg::mem_words];
	logic [icache_pkg::mem_idx_w-1:0] rd_idx;
	logic [icache_pkg::mem_idx_w-1:0] wr_idx;

	// Byte addresses become word indexes
	assign rd_idx = mem_adr[2 +: icache_pkg::mem_idx_w];
	assign wr_idx = pre_adr[2 +: icache_pkg::mem_idx_w];

	// ========================================================================
	// Handshake
	// ========================================================================

	// The ack follows the request by one cycle on both edges
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			mem_ack <= 1'b0;
		end else begin
			mem_ack <= mem_req;
		end
	end

	// Word and id are captured with the rising ack and hold until the next beat
	always_ff @(posedge clk) begin
		if (mem_req && !mem_ack) begin
			mem_rdata <= ram[rd_idx];
			mem_rtid <= mem_tid;
		end
	end

	// Preload writes come from the testbench between misses
	always_ff @(posedge clk) begin
		if (pre_we)
			ram[wr_idx] <= pre_wdata;
	end

	// A preload must not overlap any part of a beat handshake
	a_pre_quiet: assert property (@(posedge clk) disable iff (rst)
		pre_we |-> (!mem_req && !mem_ack));

endmodule

//--- hdl/icache_refill_top.sv
// Two fetch channels refill lines from one shared memory. Preload only while both channels are idle
`timescale 1ns/100ps

module icache_refill_top (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          miss_req_0,
	input  logic [icache_pkg::adr_w-1:0]  miss_adr_0,
	output logic                          miss_ack_0,
	output logic [icache_pkg::line_w-1:0] fill_data_0,
	input  logic                          miss_req_1,
	input  logic [icache_pkg::adr_w-1:0]  miss_adr_1,
	output logic                          miss_ack_1,
	output logic [icache_pkg::line_w-1:0] fill_data_1,
	input  logic                          pre_we,
	input  logic [icache_pkg::adr_w-1:0]  pre_adr,
	input  logic [icache_pkg::data_w-1:0] pre_wdata
);

	// Requester to arbiter, channel 0
	logic                          beat_req_0;
	logic [icache_pkg::adr_w-1:0]  beat_adr_0;
	logic [icache_pkg::tid_w-1:0]  beat_tid_0;
	logic                          beat_ack_0;
	logic [icache_pkg::data_w-1:0] beat_rdata_0;
	logic [icache_pkg::tid_w-1:0]  beat_rtid_0;

	// Requester to arbiter, channel 1
	logic                          beat_req_1;
	logic [icache_pkg::adr_w-1:0]  beat_adr_1;
	logic [icache_pkg::tid_w-1:0]  beat_tid_1;
	logic                          beat_ack_1;
	logic [icache_pkg::data_w-1:0] beat_rdata_1;
	logic [icache_pkg::tid_w-1:0]  beat_rtid_1;

	// Arbiter to memory
	logic                          mem_req;
	logic [icache_pkg::adr_w-1:0]  mem_adr;
	logic [icache_pkg::tid_w-1:0]  mem_tid;
	logic                          mem_ack;
	logic [icache_pkg::data_w-1:0] mem_rdata;
	logic [icache_pkg::tid_w-1:0]  mem_rtid;

	// Snoop broadcast seen by both requesters
	logic                          snoop_v;
	logic [icache_pkg::adr_w-1:0]  snoop_adr;
	icache_pkg::cid_t              snoop_cid;

	// ========================================================================
	// Requesters
	// ========================================================================

	icache_line_requester #(
		.cid(icache_pkg::cid_t'(1'b0))
	) req_0_i (
		.clk(clk),
		.rst(rst),
		.miss_req(miss_req_0),
		.miss_adr(miss_adr_0),
		.miss_ack(miss_ack_0),
		.fill_data(fill_data_0),
		.beat_req(beat_req_0),
		.beat_adr(beat_adr_0),
		.beat_tid(beat_tid_0),
		.beat_ack(beat_ack_0),
		.beat_rdata(beat_rdata_0),
		.beat_rtid(beat_rtid_0),
		.snoop_v(snoop_v),
		.snoop_adr(snoop_adr),
		.snoop_cid(snoop_cid)
	);

	icache_line_requester #(
		.cid(icache_pkg::cid_t'(1'b1))
	) req_1_i (
		.clk(clk),
		.rst(rst),
		.miss_req(miss_req_1),
		.miss_adr(miss_adr_1),
		.miss_ack(miss_ack_1),
		.fill_data(fill_data_1),
		.beat_req(beat_req_1),
		.beat_adr(beat_adr_1),
		.beat_tid(beat_tid_1),
		.beat_ack(beat_ack_1),
		.beat_rdata(beat_rdata_1),
		.beat_rtid(beat_rtid_1),
		.snoop_v(snoop_v),
		.snoop_adr(snoop_adr),
		.snoop_cid(snoop_cid)
	);

	// ========================================================================
	// Shared bus and memory
	// ========================================================================

	bus_arbiter arb_i (
		.clk(clk),
		.rst(rst),
		.beat_req_0(beat_req_0),
		.beat_adr_0(beat_adr_0),
		.beat_tid_0(beat_tid_0),
		.beat_ack_0(beat_ack_0),
		.beat_rdata_0(beat_rdata_0),
		.beat_rtid_0(beat_rtid_0),
		.beat_req_1(beat_req_1),
		.beat_adr_1(beat_adr_1),
		.beat_tid_1(beat_tid_1),
		.beat_ack_1(beat_ack_1),
		.beat_rdata_1(beat_rdata_1),
		.beat_rtid_1(beat_rtid_1),
		.mem_req(mem_req),
		.mem_adr(mem_adr),
		.mem_tid(mem_tid),
		.mem_ack(mem_ack),
		.mem_rdata(mem_rdata),
		.mem_rtid(mem_rtid),
		.snoop_v(snoop_v),
		.snoop_adr(snoop_adr),
		.snoop_cid(snoop_cid)
	);

	line_memory mem_i (
		.clk(clk),
		.rst(rst),
		.mem_req(mem_req),
		.mem_adr(mem_adr),
		.mem_tid(mem_tid),
		.mem_ack(mem_ack),
		.mem_rdata(mem_rdata),
		.mem_rtid(mem_rtid),
		.pre_we(pre_we),
		.pre_adr(pre_adr),
		.pre_wdata(pre_wdata)
	);

endmodule

//--- tb/icache_refill_checks.svh
// Compare tasks and LCG for the refill testbench. Any mismatch ends the run at once through stop_run
`ifndef ICACHE_REFILL_CHECKS_SVH
`define ICACHE_REFILL_CHECKS_SVH

// ============================================================================
// Pseudo-random source for gaps and channel start offsets
// ============================================================================

logic [31:0] lcg_state = 32'h02e4c56c;

// Classic 32-bit LCG constants, the upper bits are the better ones to use
function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

// ============================================================================
// Failure exit and compare tasks
// ============================================================================

task automatic stop_run(input string what);
	$display("%s", what);
	$display("CHECKS FAILED");
	$fatal(1, "simulation stopped at first error");
endtask

// Whole 128-bit line as seen on fill_data
task automatic compare_line(input string what, input logic [icache_pkg::line_w-1:0] got,
	input logic [icache_pkg::line_w-1:0] exp);
	if (got !== exp)
		stop_run($sformatf("CHECK FAILED at %0t: %s line got %h expected %h",
			$time, what, got, exp));
endtask

// Line base address carried in the low half of beat 0
task automatic compare_adr(input string what, input logic [icache_pkg::adr_w-1:0] got,
	input logic [icache_pkg::adr_w-1:0] exp);
	if (got !== exp)
		stop_run($sformatf("CHECK FAILED at %0t: %s address got %h expected %h",
			$time, what, got, exp));
endtask

// Single handshake bits such as miss_ack
task automatic compare_bit(input string what, input logic got, input logic exp);
	if (got !== exp)
		stop_run($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
			$time, what, got, exp));
endtask

// Event counts, for example how many fills a channel delivered
task automatic compare_count(input string what, input int got, input int exp);
	if (got != exp)
		stop_run($sformatf("CHECK FAILED at %0t: %s got %0d expected %0d",
			$time, what, got, exp));
endtask

`endif

//--- tb/icache_refill_tb.sv
// Runs from the project root. Preload words carry their byte address in the low 16 bits
`timescale 1ns/100ps

module icache_refill_tb;

	`include "icache_refill_checks.svh"

	// Generous bound, a snoop conflict may go through several back-offs
	localparam int wait_limit = 2000;

	logic                          clk;
	logic                          rst;
	logic                          miss_req_0;
	logic [icache_pkg::adr_w-1:0]  miss_adr_0;
	logic                          miss_ack_0;
	logic [icache_pkg::line_w-1:0] fill_data_0;
	logic                          miss_req_1;
	logic [icache_pkg::adr_w-1:0]  miss_adr_1;
	logic                          miss_ack_1;
	logic [icache_pkg::line_w-1:0] fill_data_1;
	logic                          pre_we;
	logic [icache_pkg::adr_w-1:0]  pre_adr;
	logic [icache_pkg::data_w-1:0] pre_wdata;

	// Records read from the input file
	logic [icache_pkg::adr_w-1:0]  pre_base_q [$];
	logic [icache_pkg::line_w-1:0] pre_line_q [$];
	int                            rec_grp_q [$];
	int                            rec_ch_q [$];
	logic [icache_pkg::adr_w-1:0]  rec_adr_q [$];
	logic [icache_pkg::line_w-1:0] rec_exp_q [$];
	int                            rec_gap_q [$];
	int                            grp_offset [$];

	// Handshake monitor state per channel
	logic prev_ack [2];
	int   ack_rises [2];
	int   misses_sent [2];

	icache_refill_top dut_i (
		.clk(clk),
		.rst(rst),
		.miss_req_0(miss_req_0),
		.miss_adr_0(miss_adr_0),
		.miss_ack_0(miss_ack_0),
		.fill_data_0(fill_data_0),
		.miss_req_1(miss_req_1),
		.miss_adr_1(miss_adr_1),
		.miss_ack_1(miss_ack_1),
		.fill_data_1(fill_data_1),
		.pre_we(pre_we),
		.pre_adr(pre_adr),
		.pre_wdata(pre_wdata)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ========================================================================
	// Handshake monitor
	// ========================================================================

	// Compares the ack edge of this clock with the request the DUT saw at it
	task automatic watch_ack(input int ch, input logic req, input logic ack);
		if (!prev_ack[ch] && ack) begin
			ack_rises[ch]++;
			compare_bit($sformatf("ch%0d miss_req when miss_ack rose", ch), req, 1'b1);
		end
		if (prev_ack[ch] && !ack)
			compare_bit($sformatf("ch%0d miss_req when miss_ack fell", ch), req, 1'b0);
		prev_ack[ch] = ack;
	endtask

	// Just after the rising edge miss_ack has settled, and miss_req still holds
	// the value the DUT sampled since it only moves on falling edges
	always @(posedge clk) begin
		#1;
		if (!rst) begin
			watch_ack(0, miss_req_0, miss_ack_0);
			watch_ack(1, miss_req_1, miss_ack_1);
		end
	end

	// ========================================================================
	// Stimulus tasks
	// ========================================================================

	task automatic read_input();
		int    fd;
		int    n;
		int    grp;
		int    ch;
		string text;
		logic [icache_pkg::adr_w-1:0]  adr;
		logic [icache_pkg::data_w-1:0] w0, w1, w2, w3;
		logic [icache_pkg::line_w-1:0] exp;
		fd = $fopen("tb/icache_refill_input.txt", "r");
		if (fd == 0)
			stop_run("Could not open tb/icache_refill_input.txt");
		while ($fgets(text, fd) != 0) begin
			if ((text.len() > 1) && (text[0] != "#")) begin
				n = $sscanf(text, "P %h %h %h %h %h", adr, w0, w1, w2, w3);
				if (n == 5) begin
					pre_base_q.push_back(adr);
					pre_line_q.push_back({w3, w2, w1, w0});
				end else if ($sscanf(text, "M %d %d %h %h", grp, ch, adr, exp) == 4) begin
					rec_grp_q.push_back(grp);
					rec_ch_q.push_back(ch);
					rec_adr_q.push_back(adr);
					rec_exp_q.push_back(exp);
					rec_gap_q.push_back(lcg_next() >> 29);
				end
			end
		end
		$fclose(fd);
	endtask

	// One word per cycle while both channels are idle
	task automatic preload_memory();
		for (int i = 0; i < pre_base_q.size(); i++) begin
			for (int b = 0; b < icache_pkg::beats_per_line; b++) begin
				@(negedge clk);
				pre_we = 1'b1;
				pre_adr = pre_base_q[i] + icache_pkg::adr_w'(b * 4);
				pre_wdata = pre_line_q[i][b * icache_pkg::data_w +: icache_pkg::data_w];
			end
		end
		@(negedge clk);
		pre_we = 1'b0;
	endtask

	task automatic do_miss(input int ch, input logic [icache_pkg::adr_w-1:0] adr,
		input logic [icache_pkg::line_w-1:0] exp);
		int   cnt;
		logic ack;
		logic [icache_pkg::line_w-1:0] fill;
		@(negedge clk);
		if (ch == 0) begin
			miss_adr_0 = adr;
			miss_req_0 = 1'b1;
		end else begin
			miss_adr_1 = adr;
			miss_req_1 = 1'b1;
		end
		misses_sent[ch]++;
		cnt = 0;
		ack = 1'b0;
		while (!ack) begin
			@(negedge clk);
			ack = (ch == 0) ? miss_ack_0 : miss_ack_1;
			cnt++;
			if (cnt > wait_limit)
				stop_run($sformatf("Timeout: channel %0d never acknowledged miss %h", ch, adr));
		end
		fill = (ch == 0) ? fill_data_0 : fill_data_1;
		compare_line($sformatf("ch%0d miss %h", ch, adr), fill, exp);
		compare_adr($sformatf("ch%0d miss %h", ch, adr), fill[15:0], adr & 16'hfff0);
		if (ch == 0)
			miss_req_0 = 1'b0;
		else
			miss_req_1 = 1'b0;
		cnt = 0;
		while (ack) begin
			@(negedge clk);
			ack = (ch == 0) ? miss_ack_0 : miss_ack_1;
			cnt++;
			if (cnt > wait_limit)
				stop_run($sformatf("Timeout: channel %0d held miss_ack after release", ch));
		end
	endtask

	// Misses of one group and one channel go out in file order
	// The first miss of a group waits only for the channel offset
	task automatic run_channel(input int ch, input int grp);
		bit first;
		first = 1'b1;
		if (ch == 1) begin
			for (int d = 0; d < grp_offset[grp]; d++)
				@(negedge clk);
		end
		for (int i = 0; i < rec_grp_q.size(); i++) begin
			if ((rec_grp_q[i] == grp) && (rec_ch_q[i] == ch)) begin
				if (!first) begin
					for (int d = 0; d < rec_gap_q[i]; d++)
						@(negedge clk);
				end
				first = 1'b0;
				do_miss(ch, rec_adr_q[i], rec_exp_q[i]);
			end
		end
	endtask

	// ========================================================================
	// Main sequence
	// ========================================================================

	initial begin
		int          last_grp;
		logic [31:0] coin;
		rst = 1'b1;
		miss_req_0 = 1'b0;
		miss_adr_0 = '0;
		miss_req_1 = 1'b0;
		miss_adr_1 = '0;
		pre_we = 1'b0;
		pre_adr = '0;
		pre_wdata = '0;
		prev_ack = '{1'b0, 1'b0};
		ack_rises = '{0, 0};
		misses_sent = '{0, 0};
		read_input();
		last_grp = 0;
		foreach (rec_grp_q[i])
			if (rec_grp_q[i] > last_grp)
				last_grp = rec_grp_q[i];
		// Half the groups start both channels in the same cycle
		for (int g = 0; g <= last_grp; g++) begin
			coin = lcg_next();
			grp_offset.push_back(coin[31] ? 0 : 1 + (lcg_next() >> 30));
		end

		// Reset for four cycles, acks must stay low through it and just after
		for (int c = 0; c < 8; c++) begin
			@(negedge clk);
			compare_bit("miss_ack_0 around reset", miss_ack_0, 1'b0);
			compare_bit("miss_ack_1 around reset", miss_ack_1, 1'b0);
			if (c == 3)
				rst = 1'b0;
		end

		preload_memory();
		for (int g = 0; g <= last_grp; g++) begin
			fork
				run_channel(0, g);
				run_channel(1, g);
			join
		end

		// Exactly one fill per miss on each channel
		@(negedge clk);
		compare_count("fills on channel 0", ack_rises[0], misses_sent[0]);
		compare_count("fills on channel 1", ack_rises[1], misses_sent[1]);

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- tb/icache_refill_input.txt
# P line_base word0 word1 word2 word3 : preload one aligned line, word n at base + 4n
# M group channel miss_adr expected_line : expected_line is {word3,word2,word1,word0}
P 0100 b0010100 b0010104 b0010108 b001010c
P 0200 b0020200 b0020204 b0020208 b002020c
P 0310 b0030310 b0030314 b0030318 b003031c
P 0020 b0040020 b0040024 b0040028 b004002c
P 0120 b0050120 b0050124 b0050128 b005012c
P 0030 b0060030 b0060034 b0060038 b006003c
P 0040 b0070040 b0070044 b0070048 b007004c
P 0050 b0080050 b0080054 b0080058 b008005c
P 0060 b0090060 b0090064 b0090068 b009006c
# Group 0: single channel, unaligned miss address
M 0 0 0104 b001010cb0010108b0010104b0010100
# Group 1: both channels, different cache indexes
M 1 0 0200 b002020cb0020208b0020204b0020200
M 1 1 0310 b003031cb0030318b0030314b0030310
# Group 2: same index, different tags, forces snoop aborts
M 2 0 0020 b004002cb0040028b0040024b0040020
M 2 1 0128 b005012cb0050128b0050124b0050120
# Group 3: back-to-back misses on each channel
M 3 0 0030 b006003cb0060038b0060034b0060030
M 3 0 0040 b007004cb0070048b0070044b0070040
M 3 1 0050 b008005cb0080058b0080054b0080050
M 3 1 0060 b009006cb0090068b0090064b0090060

//--- flist.f
+incdir+tb
hdl/icache_pkg.sv
hdl/lfsr17.sv
hdl/icache_line_requester.sv
hdl/bus_arbiter.sv
hdl/line_memory.sv
hdl/icache_refill_top.sv
tb/icache_refill_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       := icache_refill_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
